//--- Makefile
VERILATOR  := verilator
TOP        := bnn_tb
FILELIST   := src.f
LINT_FLAGS := --lint-only --timing --assert -Wall
SIM_FLAGS  := --binary --timing --assert -j 0
SIM_BIN    := obj_dir/V$(TOP)
LOG        := sim.log
PASS_TEXT  := NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN):
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- common/bnn_params.svh
`ifndef BNN_PARAMS_SVH
`define BNN_PARAMS_SVH

// ##########################################################
// network sizes
// ##########################################################

`define BNN_FEAT_CNT    4 // features per sample.
`define BNN_FEAT_BITS   4 // unsigned width of one feature.
`define BNN_HIDDEN_CNT  8 // hidden neurons in the first layer.
`define BNN_CLASS_CNT   4 // output classes.

// ##########################################################
// fixed weights
// ##########################################################

// Row j of the first layer sits at bits j*FEAT_CNT and up.
// A set bit is a weight of +1 and a clear bit a weight of -1.
`define BNN_W1 32'hA5C3_1E69

// Row k of the second layer belongs to class k.
// A set bit means the class expects a hidden bit of 1.
`define BNN_W2 32'h6ED3_A597

`endif

//--- common/bnn_pkg.sv
`include "bnn_params.svh"

package bnn_pkg;

  // ##########################################################
  // derived widths
  // ##########################################################

  localparam int SCORE_BITS = $clog2(`BNN_HIDDEN_CNT + 1); // holds 0 to HIDDEN_CNT.
  localparam int CLASS_BITS = (`BNN_CLASS_CNT > 1) ? $clog2(`BNN_CLASS_CNT) : 1;

  // ##########################################################
  // stage payloads
  // ##########################################################

  typedef struct packed {
    logic [`BNN_FEAT_CNT-1:0][`BNN_FEAT_BITS-1:0] feat; // feat[i] is feature i.
  } sample_t;

  typedef struct packed {
    logic [`BNN_HIDDEN_CNT-1:0] bits; // bits[j] is the sign of neuron j.
  } hidden_t;

  typedef struct packed {
    logic [`BNN_CLASS_CNT-1:0][SCORE_BITS-1:0] count; // count[k] is the score of class k.
  } scores_t;

  typedef struct packed {
    logic [CLASS_BITS-1:0] class_id;
    logic [SCORE_BITS-1:0] best_score;
  } result_t;

endpackage

//--- design/bnn_top.sv
`timescale 1ns/10ps
`include "bnn_params.svh"

module bnn_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              sample_valid,
  input  bnn_pkg::sample_t  sample,
  output logic              busy,
  output logic              class_valid,
  output bnn_pkg::result_t  result
);

  bnn_pkg::hidden_t  hidden;
  logic              hidden_valid;
  bnn_pkg::scores_t  scores;
  logic              scores_valid;

  // ##########################################################
  // three stage pipeline
  // ##########################################################

  // the first layer drops a strobe that arrives while it is busy.
  first_layer_seq u_first_layer (
    .clk          (clk),
    .rst          (rst),
    .start        (sample_valid),
    .sample       (sample),
    .busy         (busy),
    .hidden       (hidden),
    .hidden_valid (hidden_valid)
  );

  xnor_popcount_layer u_second_layer (
    .clk          (clk),
    .rst          (rst),
    .hidden       (hidden),
    .hidden_valid (hidden_valid),
    .scores       (scores),
    .scores_valid (scores_valid)
  );

  class_argmax u_argmax (
    .clk          (clk),
    .rst          (rst),
    .scores       (scores),
    .scores_valid (scores_valid),
    .result       (result),
    .class_valid  (class_valid)
  );

endmodule

//--- design/class_argmax.sv
`timescale 1ns/10ps
`include "bnn_params.svh"

module class_argmax (
  input  logic              clk,
  input  logic              rst,
  input  bnn_pkg::scores_t  scores,
  input  logic              scores_valid,
  output bnn_pkg::result_t  result,
  output logic              class_valid
);

  localparam int CLASS_CNT  = `BNN_CLASS_CNT;
  localparam int CLASS_BITS = bnn_pkg::CLASS_BITS;

  bnn_pkg::result_t best;

  // ##########################################################
  // winner search
  // ##########################################################

  // Only a strictly larger count replaces the candidate. The lowest index wins a tie.
  always_comb begin
    best.class_id   = '0;
    best.best_score = scores.count[0];
    for (int k = 1; k < CLASS_CNT; k++) begin
      if (scores.count[k] > best.best_score) begin
        best.class_id   = CLASS_BITS'(k);
        best.best_score = scores.count[k];
      end
    end
  end

  // ##########################################################
  // result register
  // ##########################################################

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      class_valid <= 1'b0;
    end else begin
      class_valid <= scores_valid; // one pulse per score set.
    end
  end

  always_ff @(posedge clk) begin
    if (scores_valid) begin
      result <= best;
    end
  end

endmodule

//--- design/xnor_popcount_layer.sv
`timescale 1ns/10ps
`include "bnn_params.svh"

module xnor_popcount_layer (
  input  logic              clk,
  input  logic              rst,
  input  bnn_pkg::hidden_t  hidden,
  input  logic              hidden_valid,
  output bnn_pkg::scores_t  scores,
  output logic              scores_valid
);

  localparam int HIDDEN_CNT = `BNN_HIDDEN_CNT;
  localparam int CLASS_CNT  = `BNN_CLASS_CNT;
  localparam int SCORE_BITS = bnn_pkg::SCORE_BITS;

  localparam logic [CLASS_CNT*HIDDEN_CNT-1:0] W2 = `BNN_W2;

  // ##########################################################
  // agreement count per class
  // ##########################################################

  function automatic logic [SCORE_BITS-1:0] ones_count(input logic [HIDDEN_CNT-1:0] bits);
    logic [SCORE_BITS-1:0] n;
    n = '0;
    for (int j = 0; j < HIDDEN_CNT; j++) begin
      n = n + SCORE_BITS'(bits[j]);
    end
    return n;
  endfunction

  bnn_pkg::scores_t score_d;
  logic [HIDDEN_CNT-1:0] agree;

  always_comb begin
    score_d = '0;
    agree = '0;
    for (int k = 0; k < CLASS_CNT; k++) begin
      agree = hidden.bits ~^ W2[k*HIDDEN_CNT +: HIDDEN_CNT]; // set where bit matches weight.
      score_d.count[k] = ones_count(agree);
    end
  end

  // ##########################################################
  // output register
  // ##########################################################

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      scores_valid <= 1'b0;
    end else begin
      scores_valid <= hidden_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (hidden_valid) begin
      scores <= score_d;
    end
  end

endmodule

//--- first_layer/first_layer_seq.sv
`timescale 1ns/10ps
`include "bnn_params.svh"

module first_layer_seq (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  bnn_pkg::sample_t  sample,
  output logic              busy,
  output bnn_pkg::hidden_t  hidden,
  output logic              hidden_valid
);

  localparam int FEAT_CNT   = `BNN_FEAT_CNT;
  localparam int FEAT_BITS  = `BNN_FEAT_BITS;
  localparam int HIDDEN_CNT = `BNN_HIDDEN_CNT;
  localparam int CNT_LEN    = $clog2(HIDDEN_CNT + 1);
  localparam int NEG_BITS   = $clog2(FEAT_CNT + 1);
  localparam int SUM_BITS   = FEAT_BITS + $clog2(FEAT_CNT + 1) + 1;

  localparam logic [HIDDEN_CNT*FEAT_CNT-1:0] W1 = `BNN_W1;

  typedef logic [2**CNT_LEN-1:0][FEAT_CNT-1:0] row_map_t;
  typedef logic [2**CNT_LEN-1:0][NEG_BITS-1:0] neg_map_t;

  // ##########################################################
  // neuron order and weight tables
  // ##########################################################

  function automatic logic [CNT_LEN-1:0] lfsr_step(input logic [CNT_LEN-1:0] state);
    return {state[CNT_LEN-2:0], state[CNT_LEN-1] ~^ state[CNT_LEN-2]};
  endfunction

  function automatic logic [CNT_LEN-1:0] lfsr_n(input int n);
    logic [CNT_LEN-1:0] state;
    state = '0;
    for (int i = 0; i < n; i++) begin
      state = lfsr_step(state);
    end
    return state;
  endfunction

  function automatic logic [NEG_BITS-1:0] neg_count(input logic [FEAT_CNT-1:0] row);
    logic [NEG_BITS-1:0] n;
    n = '0;
    for (int i = 0; i < FEAT_CNT; i++) begin
      n = n + NEG_BITS'(!row[i]);
    end
    return n;
  endfunction

  function automatic row_map_t build_row_map();
    row_map_t map;
    map = '0;
    for (int j = 0; j < HIDDEN_CNT; j++) begin
      map[lfsr_n(j)] = W1[j*FEAT_CNT +: FEAT_CNT];
    end
    return map;
  endfunction

  function automatic neg_map_t build_neg_map();
    neg_map_t map;
    map = '0;
    for (int j = 0; j < HIDDEN_CNT; j++) begin
      map[lfsr_n(j)] = neg_count(W1[j*FEAT_CNT +: FEAT_CNT]);
    end
    return map;
  endfunction

  // The xnor counter never visits all ones, so 8 neurons fit in 4 bits.
  localparam logic [CNT_LEN-1:0] SEED_STATE = lfsr_n(0);
  localparam logic [CNT_LEN-1:0] LAST_STATE = lfsr_n(HIDDEN_CNT - 1);
  localparam logic [CNT_LEN-1:0] END_STATE  = lfsr_n(HIDDEN_CNT);
  localparam row_map_t ROW_MAP = build_row_map();
  localparam neg_map_t NEG_MAP = build_neg_map();

  logic [CNT_LEN-1:0]          cnt;
  bnn_pkg::sample_t            sample_q;
  logic [FEAT_CNT-1:0]         row;
  logic [FEAT_BITS:0]          term;
  logic signed [SUM_BITS-1:0]  sum;

  assign busy = (cnt != END_STATE); // idle parks the counter on the end state.
  assign row  = ROW_MAP[cnt];

  // ##########################################################
  // signed sum of the current neuron
  // ##########################################################

  // A clear weight bit gives ~f which is -f-1. The negative count puts the ones back.
  always_comb begin
    sum = signed'({{(SUM_BITS-NEG_BITS){1'b0}}, NEG_MAP[cnt]});
    term = '0;
    for (int i = 0; i < FEAT_CNT; i++) begin
      term = {(FEAT_BITS+1){row[i]}} ~^ {1'b0, sample_q.feat[i]};
      sum = sum + signed'({{(SUM_BITS-FEAT_BITS-1){term[FEAT_BITS]}}, term});
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt          <= END_STATE;
      hidden_valid <= 1'b0;
    end else begin
      hidden_valid <= busy && (cnt == LAST_STATE); // last neuron lands on this edge.
      if (!busy && start) begin
        cnt <= SEED_STATE;
      end else if (busy) begin
        cnt <= lfsr_step(cnt);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!busy && start) begin
      sample_q <= sample;
    end
    if (busy) begin
      hidden.bits <= {~sum[SUM_BITS-1], hidden.bits[HIDDEN_CNT-1:1]}; // neuron 0 ends in bit 0.
    end
  end

endmodule

//--- src.f
+incdir+common
common/bnn_pkg.sv
first_layer/first_layer_seq.sv
design/xnor_popcount_layer.sv
design/class_argmax.sv
design/bnn_top.sv
verif/bnn_properties.sv
verif/bnn_checker.sv
verif/bnn_tb.sv

//--- verif/bnn_checker.sv
`timescale 1ns/10ps
`include "bnn_params.svh"

module bnn_checker (
  input  logic              clk,
  input  logic              rst,
  input  logic              sample_valid,
  input  logic              busy,
  input  bnn_pkg::sample_t  sample,
  input  logic              class_valid,
  input  bnn_pkg::result_t  result,
  output int                check_cnt,
  output int                error_cnt,
  output int                pending_cnt
);

  localparam int FEAT_CNT   = `BNN_FEAT_CNT;
  localparam int HIDDEN_CNT = `BNN_HIDDEN_CNT;
  localparam int CLASS_CNT  = `BNN_CLASS_CNT;
  localparam int CLASS_BITS = bnn_pkg::CLASS_BITS;
  localparam int SCORE_BITS = bnn_pkg::SCORE_BITS;
  localparam int RESULT_LAT = HIDDEN_CNT + 2; // edges from acceptance to the edge raising class_valid.

  localparam logic [HIDDEN_CNT*FEAT_CNT-1:0]  W1 = `BNN_W1;
  localparam logic [CLASS_CNT*HIDDEN_CNT-1:0] W2 = `BNN_W2;

  bnn_pkg::sample_t sample_q[$];
  int               accept_q[$];
  int               cyc = 0;
  int               checks = 0;
  int               errors = 0;
  int               pending = 0;

  assign check_cnt   = checks;
  assign error_cnt   = errors;
  assign pending_cnt = pending;

  // ##########################################################
  // reference classifier
  // ##########################################################

  function automatic bnn_pkg::result_t ref_classify(input bnn_pkg::sample_t s);
    bnn_pkg::result_t      r;
    logic [HIDDEN_CNT-1:0] h;
    int                    acc;
    int                    score;
    int                    best_k;
    int                    best_s;
    h = '0;
    for (int j = 0; j < HIDDEN_CNT; j++) begin
      acc = 0;
      for (int i = 0; i < FEAT_CNT; i++) begin
        if (W1[j*FEAT_CNT + i]) begin
          acc = acc + int'(s.feat[i]);
        end else begin
          acc = acc - int'(s.feat[i]);
        end
      end
      h[j] = (acc >= 0); // a zero sum counts as positive.
    end
    best_k = 0;
    best_s = -1;
    for (int k = 0; k < CLASS_CNT; k++) begin
      score = 0;
      for (int j = 0; j < HIDDEN_CNT; j++) begin
        if (h[j] == W2[k*HIDDEN_CNT + j]) begin
          score++;
        end
      end
      if (score > best_s) begin
        best_k = k;
        best_s = score;
      end
    end
    r.class_id   = CLASS_BITS'(best_k);
    r.best_score = SCORE_BITS'(best_s);
    return r;
  endfunction

  // ##########################################################
  // compare process
  // ##########################################################

  always @(posedge clk or posedge rst) begin
    bnn_pkg::result_t expect_res;
    bnn_pkg::sample_t s;
    int               lat;
    if (rst) begin
      sample_q.delete(); // results in flight are lost on reset.
      accept_q.delete();
    end else begin
      cyc++;
      if (class_valid) begin
        if (sample_q.size() == 0) begin
          $display("unexpected result at %0t: class_valid with no accepted sample waiting",
                   $time);
          errors++;
        end else begin
          s          = sample_q.pop_front();
          lat        = cyc - accept_q.pop_front() - 1; // pulse is seen one edge after it rises.
          expect_res = ref_classify(s);
          checks++;
          if (result !== expect_res) begin
            $display("mismatch at %0t: sample %h gave class %0d score %0d, expected %0d score %0d",
                     $time, s.feat, result.class_id, result.best_score,
                     expect_res.class_id, expect_res.best_score);
            errors++;
          end
          if (lat != RESULT_LAT) begin
            $display("mismatch at %0t: result came %0d edges after acceptance, expected %0d",
                     $time, lat, RESULT_LAT);
            errors++;
          end
        end
      end
      if (sample_valid && !busy) begin
        sample_q.push_back(sample);
        accept_q.push_back(cyc);
      end
    end
    pending = sample_q.size();
  end

endmodule

//--- verif/bnn_properties.sv
`timescale 1ns/10ps
`include "bnn_params.svh"

module bnn_properties (
  input logic              clk,
  input logic              rst,
  input logic              sample_valid,
  input logic              busy,
  input bnn_pkg::hidden_t  hidden,
  input logic              hidden_valid,
  input logic              class_valid
);

  localparam int HIDDEN_CNT = `BNN_HIDDEN_CNT;

  // ##########################################################
  // pipeline control
  // ##########################################################

  single_pulse: assert property (@(posedge clk) disable iff (rst)
    class_valid |=> !class_valid)
    else $error("class_valid stayed high for two cycles");

  idle_after_reset: assert property (@(posedge clk)
    $fell(rst) |-> !busy && !class_valid)
    else $error("busy or class_valid high right after reset");

  hidden_to_class: assert property (@(posedge clk) disable iff (rst)
    hidden_valid |-> ##2 class_valid)
    else $error("class_valid did not follow hidden_valid two cycles later");

  // one neuron per cycle keeps the layer busy for the whole hidden vector.
  busy_length: assert property (@(posedge clk) disable iff (rst)
    sample_valid && !busy |=> busy [*HIDDEN_CNT] ##1 !busy)
    else $error("busy did not last exactly one cycle per hidden neuron");

  hidden_known: assert property (@(posedge clk) disable iff (rst)
    hidden_valid |-> !$isunknown(hidden))
    else $error("hidden vector unknown while hidden_valid is high");

endmodule

//--- verif/bnn_tb.sv
`timescale 1ns/10ps
`include "bnn_params.svh"

module bnn_tb;

  localparam int FEAT_CNT      = `BNN_FEAT_CNT;
  localparam int FEAT_BITS     = `BNN_FEAT_BITS;
  localparam int HIDDEN_CNT    = `BNN_HIDDEN_CNT;
  localparam int CLK_NS        = 4;
  localparam int RST_CYCLES    = 10;
  localparam int RAND_CNT      = 200;
  localparam int MAX_GAP       = 7;
  localparam int STROBE_CYCLES = 60;
  localparam int DRAIN_CYCLES  = 2 * (HIDDEN_CNT + 4);
  localparam int SAMPLE_CNT    = 1 + (1 + FEAT_CNT) + RAND_CNT + STROBE_CYCLES + 2;
  localparam int WATCHDOG_NS   = SAMPLE_CNT * (HIDDEN_CNT + 4) * CLK_NS
                               + RAND_CNT * MAX_GAP * CLK_NS + 100 * CLK_NS;
  localparam int SAMPLE_BITS   = $bits(bnn_pkg::sample_t);
  localparam logic [FEAT_BITS-1:0] FEAT_MAX = '1;

  logic              clk;
  logic              rst;
  logic              sample_valid;
  bnn_pkg::sample_t  sample;
  logic              busy;
  logic              class_valid;
  bnn_pkg::result_t  result;

  int     check_cnt;
  int     error_cnt;
  int     pending_cnt;
  int     fail_cnt;   // failures seen by the testbench itself.
  int     test_cnt;
  int     base_checks;
  int     base_fails;
  integer seed;

  bnn_top DUT (
    .clk          (clk),
    .rst          (rst),
    .sample_valid (sample_valid),
    .sample       (sample),
    .busy         (busy),
    .class_valid  (class_valid),
    .result       (result)
  );

  bnn_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .sample_valid (sample_valid),
    .busy         (busy),
    .sample       (sample),
    .class_valid  (class_valid),
    .result       (result),
    .check_cnt    (check_cnt),
    .error_cnt    (error_cnt),
    .pending_cnt  (pending_cnt)
  );

  bind bnn_top bnn_properties u_properties (
    .clk          (clk),
    .rst          (rst),
    .sample_valid (sample_valid),
    .busy         (busy),
    .hidden       (hidden),
    .hidden_valid (hidden_valid),
    .class_valid  (class_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS/2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $finish;
  end

  // ##########################################################
  // drive and bookkeeping tasks
  // ##########################################################

  task automatic send_sample(input bnn_pkg::sample_t s);
    @(negedge clk);
    while (busy) begin
      @(negedge clk);
    end
    sample_valid = 1'b1;
    sample       = s;
    @(negedge clk);
    sample_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (pending_cnt != 0 && waited < DRAIN_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (pending_cnt != 0) begin
      $display("missing result at %0t: %0d accepted samples got no class_valid",
               $time, pending_cnt);
      fail_cnt++;
    end
    repeat (2) @(negedge clk); // room for a stray extra pulse to show.
  endtask

  task automatic open_test();
    base_checks = check_cnt;
    base_fails  = error_cnt + fail_cnt;
  endtask

  task automatic close_test(input string name);
    test_cnt++;
    $display("test %s: %0d results checked, %0d failures", name,
             check_cnt - base_checks, error_cnt + fail_cnt - base_fails);
  endtask

  // ##########################################################
  // tests
  // ##########################################################

  task automatic zero_features_test();
    open_test();
    send_sample('0);
    wait_drain();
    close_test("zero features");
  endtask

  task automatic extreme_features_test();
    bnn_pkg::sample_t s;
    open_test();
    for (int i = 0; i < FEAT_CNT; i++) begin
      s.feat[i] = FEAT_MAX;
    end
    send_sample(s);
    for (int i = 0; i < FEAT_CNT; i++) begin
      s         = '0;
      s.feat[i] = FEAT_MAX;
      send_sample(s);
    end
    wait_drain();
    close_test("max and single-hot features");
  endtask

  task automatic random_samples_test();
    int gap;
    open_test();
    for (int n = 0; n < RAND_CNT; n++) begin
      gap = $random(seed) & MAX_GAP;
      while (busy) begin
        @(negedge clk);
      end
      repeat (gap) @(negedge clk); // idle cycles counted from the end of busy.
      send_sample(SAMPLE_BITS'($random(seed)));
    end
    wait_drain();
    close_test("random samples");
  endtask

  task automatic busy_strobe_test();
    open_test();
    for (int c = 0; c < STROBE_CYCLES; c++) begin
      @(negedge clk);
      sample_valid = 1'b1; // held high through busy so only idle edges accept.
      sample       = SAMPLE_BITS'($random(seed));
    end
    @(negedge clk);
    sample_valid = 1'b0;
    wait_drain();
    close_test("strobes while busy");
  endtask

  task automatic reset_mid_run_test();
    open_test();
    send_sample(SAMPLE_BITS'($random(seed)));
    repeat (HIDDEN_CNT/2) @(negedge clk);
    rst = 1'b1;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    if (pending_cnt != 0) begin
      $display("checker queue still holds %0d samples after reset at %0t", pending_cnt, $time);
      fail_cnt++;
    end
    for (int c = 0; c < 3 * HIDDEN_CNT; c++) begin
      @(negedge clk);
      if (busy || class_valid) begin
        $display("busy or class_valid went high after reset with no sample accepted at %0t",
                 $time);
        fail_cnt++;
      end
    end
    send_sample(SAMPLE_BITS'($random(seed)));
    wait_drain();
    close_test("reset mid-computation");
  endtask

  // ##########################################################
  // main sequence
  // ##########################################################

  initial begin
    seed         = 32'h18b0;
    rst          = 1'b1;
    sample_valid = 1'b0;
    sample       = '0;
    fail_cnt     = 0;
    test_cnt     = 0;
    base_checks  = 0;
    base_fails   = 0;
    repeat (RST_CYCLES) @(negedge clk);
    rst = 1'b0;
    zero_features_test();
    extreme_features_test();
    random_samples_test();
    busy_strobe_test();
    reset_mid_run_test();
    $display("tests %0d, results checked %0d, failures %0d",
             test_cnt, check_cnt, error_cnt + fail_cnt);
    if (error_cnt + fail_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
